//--- Makefile
# Verilator build and run of the cartridge loader testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_nes_cart_loader
FILELIST = src.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)

.PHONY: simulate clean

# The run passes only if the log holds the pass line
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_cart_loader_tests.svh
// ********************
// Directed loader tests plus the image and flags model.
// Included inside the testbench top module
// ********************
`ifndef TB_CART_LOADER_TESTS_SVH
`define TB_CART_LOADER_TESTS_SVH

function automatic void build_header(input int prg, input int chr, input logic [7:0] f6,
		input logic [7:0] f7, input logic [63:0] ext);
	hdr[0] = INES_SIG0;
	hdr[1] = INES_SIG1;
	hdr[2] = INES_SIG2;
	hdr[3] = INES_SIG3;
	hdr[4] = 8'(prg);
	hdr[5] = 8'(chr);
	hdr[6] = f6;
	hdr[7] = f7;
	for (int i = 0; i < 8; i++)
		hdr[8 + i] = ext[8*i +: 8]; // Byte 8 in the low bits
endfunction

// Smallest k with pages <= 2^k, at most 7
function automatic size_code_t page_code(input int pages);
	int k;
	k = 0;
	while (k < 7 && (1 << k) < pages)
		k++;
	return size_code_t'(k);
endfunction

function automatic mapper_flags_t expected_flags(input logic inv);
	mapper_flags_t f;
	logic          nes20;
	logic          dirty;
	nes20 = (hdr[7][3:2] == NES20_ID_VALUE);
	dirty = 1'b0;
	for (int i = 8; i < INES_HEADER_BYTES; i++)
		dirty = dirty | (hdr[i] != 8'h00);
	dirty = dirty & !nes20;
	f = '0;
	f[FLAGS_MAPPER_MSB:FLAGS_MAPPER_LSB] = {dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	f[FLAGS_PRG_SIZE_MSB:FLAGS_PRG_SIZE_LSB] = page_code(hdr[4]);
	f[FLAGS_CHR_SIZE_MSB:FLAGS_CHR_SIZE_LSB] = page_code(hdr[5]);
	f[FLAGS_MIRROR_BIT] = hdr[6][FLAGS6_MIRROR_BIT] ^ inv;
	f[FLAGS_CHR_RAM_BIT] = (hdr[5] == 8'h00);
	f[FLAGS_FOUR_SCREEN_BIT] = hdr[6][FLAGS6_FOUR_SCREEN_BIT];
	if (nes20)
		f[FLAGS_NES20_B8_MSB:FLAGS_NES20_B8_LSB] = hdr[8];
	return f;
endfunction

task automatic check_flags(input logic inv);
	mapper_flags_t exp;
	exp = expected_flags(inv);
	check_true(mapper_flags == exp,
		$sformatf("mapper_flags %h, expected %h", mapper_flags, exp));
endtask

// PRG bytes from PRG_BASE, then CHR bytes from CHR_BASE, nothing more
task automatic check_writes(input int prg_n, input int chr_n);
	int         prg_len;
	int         total;
	int         bad;
	cart_addr_t exp_addr;
	string      msg;
	prg_len = prg_n * PRG_PAGE_BYTES;
	total = prg_len + chr_n * CHR_PAGE_BYTES;
	bad = -1;
	msg = "";
	check_true(wr_addr_q.size() == total,
		$sformatf("%0d memory writes, expected %0d", wr_addr_q.size(), total));
	for (int i = 0; i < total && i < wr_addr_q.size() && bad < 0; i++) begin
		exp_addr = (i < prg_len) ? PRG_BASE + cart_addr_t'(i) :
			CHR_BASE + cart_addr_t'(i - prg_len);
		if (wr_addr_q[i] != exp_addr || wr_data_q[i] != body_q[i]) begin
			bad = i;
			msg = $sformatf("write %0d went to %h with %h, expected %h with %h",
				i, wr_addr_q[i], wr_data_q[i], exp_addr, body_q[i]);
		end
	end
	check_true(bad < 0, msg);
endtask

task automatic load_image(input logic inv, input int body_len);
	start_download(inv);
	send_image(body_len);
	wait_done();
endtask

task automatic load_header_only(input logic inv);
	start_download(inv);
	send_image(0);
	check_flags(inv); // Flags settle 2 cycles after the last header byte
	end_download();
endtask

task automatic check_rejected(input string what);
	check_true(done === 1'b1 && error === 1'b1, {what, " must set done and error"});
	check_true(wr_addr_q.size() == 0,
		$sformatf("%s gave %0d memory writes", what, wr_addr_q.size()));
endtask

task automatic load_one_prg_one_chr();
	int errs;
	errs = check_errors;
	build_header(1, 1, 8'h01, 8'h00, 64'h0);
	load_image(1'b0, PRG_PAGE_BYTES + CHR_PAGE_BYTES);
	check_writes(1, 1);
	check_true(done === 1'b1 && error === 1'b0, "good image must end with done and no error");
	check_flags(1'b0);
	end_download();
	report_test("one PRG and one CHR page", errs);
endtask

task automatic decode_flags_cases();
	int errs;
	errs = check_errors;
	build_header(3, 2, 8'h41, 8'h10, 64'h0); // Mapper 20, vertical
	load_header_only(1'b0);
	check_true(mapper_flags[FLAGS_PRG_SIZE_MSB:FLAGS_PRG_SIZE_LSB] == 3'd2,
		"3 PRG pages must give size code 2");
	load_header_only(1'b1);
	check_true(mapper_flags[FLAGS_MIRROR_BIT] == 1'b0, "inverted mirroring not applied");
	build_header(2, 0, 8'h08, 8'h00, 64'h0);
	load_header_only(1'b0);
	check_true(mapper_flags[FLAGS_FOUR_SCREEN_BIT] && mapper_flags[FLAGS_CHR_RAM_BIT],
		"four-screen and CHR RAM bits expected");
	report_test("flags decode", errs);
endtask

task automatic dirty_and_nes20_headers();
	int errs;
	errs = check_errors;
	build_header(1, 1, 8'h20, 8'h30, 64'h2165_6475_4420_6B73); // Ripper text in 8 to 15
	load_header_only(1'b0);
	check_true(mapper_flags[7:4] == 4'h0, "dirty header kept the upper mapper nibble");
	build_header(1, 1, 8'h20, 8'h38, 64'h0000_0007_0000_005A);
	load_header_only(1'b0);
	check_true(mapper_flags[FLAGS_MAPPER_MSB:FLAGS_MAPPER_LSB] == 8'h32 &&
		mapper_flags[FLAGS_NES20_B8_MSB:FLAGS_NES20_B8_LSB] == 8'h5A,
		"NES 2.0 header lost mapper nibble or byte 8");
	report_test("dirty and NES 2.0 headers", errs);
endtask

task automatic reject_bad_headers();
	int errs;
	errs = check_errors;
	build_header(1, 0, 8'h00, 8'h00, 64'h0);
	hdr[0] = 8'h4D;
	load_image(1'b0, 64);
	check_rejected("bad signature");
	end_download();
	build_header(1, 0, 8'h04, 8'h00, 64'h0); // Trainer present
	load_image(1'b0, 64);
	check_rejected("trainer bit");
	end_download();
	report_test("bad headers", errs);
endtask

task automatic ignore_trailing_bytes();
	int errs;
	errs = check_errors;
	build_header(1, 0, 8'h00, 8'h00, 64'h0);
	load_image(1'b0, PRG_PAGE_BYTES + 100);
	check_writes(1, 0);
	check_true(done === 1'b1 && error === 1'b0, "trailing bytes changed done or error");
	end_download();
	report_test("trailing bytes", errs);
endtask

task automatic reload_after_failure();
	int errs;
	errs = check_errors;
	build_header(1, 0, 8'h00, 8'h00, 64'h0);
	hdr[3] = 8'h00;
	load_image(1'b0, 16);
	check_rejected("first download");
	end_download();
	build_header(1, 0, 8'h21, 8'h00, 64'h0);
	start_download(1'b1);
	check_true(done === 1'b0 && error === 1'b0, "new download did not clear done and error");
	send_image(PRG_PAGE_BYTES);
	wait_done();
	check_writes(1, 0);
	check_true(error === 1'b0, "error set on the second download");
	check_flags(1'b1);
	end_download();
	report_test("reload after failure", errs);
endtask

`endif

//--- dv/tb_nes_cart_loader.sv
// ********************
// Testbench top for the cartridge loader. Clock, reset, DUT,
// memory write monitor and timeout. Directed tests are in the .svh
// ********************
`timescale 1ns/100ps
`default_nettype none

module tb_nes_cart_loader;
	import nes_format_pkg::*;
	import nes_cart_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 4;
	localparam int CE_PERIOD = 4;
	localparam int BYTE_GAP = 6; // Cycles from one byte strobe to the next
	localparam int TOTAL_BYTES = 58_000; // All images of all tests rounded up
	localparam int TIMEOUT_CYCLES = TOTAL_BYTES * BYTE_GAP + 50_000;
	localparam logic [31:0] RANDOM_SEED = 32'hd5f1_e80a;

	logic          clk;
	logic          reset;
	logic          downloading;
	logic          byte_valid;
	logic [7:0]    byte_data;
	logic          invert_mirroring;
	logic          mem_write;
	cart_addr_t    mem_addr;
	logic [7:0]    mem_data;
	logic          done;
	logic          error;
	mapper_flags_t mapper_flags;

	logic [7:0] hdr [INES_HEADER_BYTES]; // Header of the image under test
	logic [7:0] body_q [$];              // Body bytes as sent
	cart_addr_t wr_addr_q [$];
	logic [7:0] wr_data_q [$];
	int         write_gap; // Cycles since the last write, -1 before the first one
	int         check_errors;
	int         tests_run;
	int         tests_failed;
	int         cycle_count;

	nes_cart_loader #(
		.CE_PERIOD(CE_PERIOD)
	) DUT (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.invert_mirroring(invert_mirroring),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.done(done),
		.error(error),
		.mapper_flags(mapper_flags)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Every released write in order
	always @(posedge clk) begin
		if (write_gap >= 0)
			write_gap++;
		if (!reset && mem_write) begin
			// The memory slot comes round once every CE_PERIOD clocks
			if (write_gap >= 0)
				check_true(write_gap % CE_PERIOD == 0,
					$sformatf("write %0d cycles after the previous one, outside the memory slot",
						write_gap));
			wr_addr_q.push_back(mem_addr);
			wr_data_q.push_back(mem_data);
			write_gap = 0;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_true(input logic cond, input string msg);
		assert (cond) else begin
			$display("CHECK FAILED at %0t ns: %s", $time, msg);
			check_errors++;
		end
	endtask

	task automatic send_byte(input logic [7:0] value);
		@(posedge clk);
		byte_valid <= 1'b1;
		byte_data <= value;
		@(posedge clk);
		byte_valid <= 1'b0;
		repeat (BYTE_GAP - 2) @(posedge clk);
	endtask

	// Raises downloading and returns once load_start has cleared done and error
	task automatic start_download(input logic inv);
		body_q.delete();
		wr_addr_q.delete();
		wr_data_q.delete();
		@(posedge clk);
		downloading <= 1'b1;
		invert_mirroring <= inv;
		repeat (3) @(posedge clk);
	endtask

	task automatic end_download();
		@(posedge clk);
		downloading <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic send_image(input int body_len);
		logic [7:0] value;
		for (int i = 0; i < INES_HEADER_BYTES; i++)
			send_byte(hdr[i]);
		for (int i = 0; i < body_len; i++) begin
			value = 8'($urandom);
			body_q.push_back(value);
			send_byte(value);
		end
	endtask

	// Last write leaves the slot stage at most CE_PERIOD cycles after done
	task automatic wait_done();
		while (done !== 1'b1)
			@(posedge clk);
		repeat (CE_PERIOD + 2) @(posedge clk);
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (check_errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: FAILED with %0d errors", name, check_errors - errs_before);
		end
	endtask

	`include "tb_cart_loader_tests.svh"

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		downloading = 1'b0;
		byte_valid = 1'b0;
		byte_data = 8'h00;
		invert_mirroring = 1'b0;
		write_gap = -1;
		check_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycle_count = 0;
		void'($urandom(RANDOM_SEED));
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);

		load_one_prg_one_chr();
		decode_flags_cases();
		dirty_and_nes20_headers();
		reject_bad_headers();
		ignore_trailing_bytes();
		reload_after_failure();

		$display("Tests run %0d, failed %0d, failed checks %0d",
			tests_run, tests_failed, check_errors);
		if (check_errors == 0 && tests_failed == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+dv
src/nes_format_pkg.sv
src/nes_cart_pkg.sv
src/ines_header_capture.sv
src/mapper_flags_decode.sv
src/rom_stream_writer.sv
src/mem_write_stage.sv
src/nes_cart_loader.sv
dv/tb_nes_cart_loader.sv

//--- src/ines_header_capture.sv
// ********************
// First loader stage. Collects the 16-byte iNES header, checks it and
// passes every later byte on as a body strobe
// ********************
`timescale 1ns/100ps
`default_nettype none

module ines_header_capture (
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                downloading,
	input  wire                                byte_valid,
	input  wire nes_format_pkg::header_byte_t  byte_data,
	output logic                               load_start,
	output logic                               hdr_ok,
	output logic                               hdr_bad,
	output logic                               body_valid,
	output nes_format_pkg::header_byte_t       body_data,
	output nes_format_pkg::header_byte_t       prg_pages,
	output nes_format_pkg::header_byte_t       chr_pages,
	output nes_format_pkg::header_byte_t       flags6,
	output nes_format_pkg::header_byte_t       flags7,
	output nes_format_pkg::header_byte_t [7:0] ext_bytes
);
	import nes_format_pkg::*;

	localparam int CNT_W = $clog2(INES_HEADER_BYTES + 1);
	localparam int IDX_W = $clog2(INES_HEADER_BYTES);
	localparam logic [CNT_W-1:0] HDR_LAST = CNT_W'(INES_HEADER_BYTES - 1);
	localparam logic [CNT_W-1:0] HDR_FULL = CNT_W'(INES_HEADER_BYTES);

	// Field positions in the header
	localparam int PRG_IDX = 4;
	localparam int CHR_IDX = 5;
	localparam int F6_IDX = 6;
	localparam int F7_IDX = 7;
	localparam int EXT_IDX = 8;

	logic             dl_q;
	logic             dl_rise;
	logic             accept;
	logic             in_body;
	logic             hdr_good;
	logic [CNT_W-1:0] hdr_cnt; // Header bytes seen, stops at 16
	header_byte_t     hdr_q [INES_HEADER_BYTES];

	assign dl_rise = downloading && !dl_q;
	assign accept = downloading && byte_valid && !dl_rise;
	assign in_body = (hdr_cnt == HDR_FULL);

	// Bytes 0 to 6 are already stored when byte 16 arrives
	assign hdr_good = (hdr_q[0] == INES_SIG0) && (hdr_q[1] == INES_SIG1) &&
		(hdr_q[2] == INES_SIG2) && (hdr_q[3] == INES_SIG3) &&
		!hdr_q[F6_IDX][FLAGS6_TRAINER_BIT];

	always_ff @(posedge clk) begin
		if (reset) begin
			dl_q <= 1'b0;
			load_start <= 1'b0;
			hdr_ok <= 1'b0;
			hdr_bad <= 1'b0;
			body_valid <= 1'b0;
			hdr_cnt <= '0;
		end else begin
			dl_q <= downloading;
			load_start <= dl_rise;
			hdr_ok <= 1'b0;
			hdr_bad <= 1'b0;
			body_valid <= 1'b0;
			if (dl_rise) begin
				hdr_cnt <= '0; // New image, start over
			end else if (accept) begin
				if (in_body) begin
					body_valid <= 1'b1;
				end else begin
					hdr_cnt <= hdr_cnt + 1'b1;
					if (hdr_cnt == HDR_LAST) begin
						hdr_ok <= hdr_good;
						hdr_bad <= !hdr_good;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !in_body)
			hdr_q[hdr_cnt[IDX_W-1:0]] <= byte_data;
		if (accept)
			body_data <= byte_data;
	end

	assign prg_pages = hdr_q[PRG_IDX];
	assign chr_pages = hdr_q[CHR_IDX];
	assign flags6 = hdr_q[F6_IDX];
	assign flags7 = hdr_q[F7_IDX];

	always_comb begin
		for (int i = 0; i < 8; i++)
			ext_bytes[i] = hdr_q[EXT_IDX + i];
	end

endmodule

`default_nettype wire

//--- src/mapper_flags_decode.sv
// ********************
// Builds the 32-bit mapper flags word from the captured header.
// Loaded on hdr_ok, cleared at the start of each download
// ********************
`timescale 1ns/100ps
`default_nettype none

module mapper_flags_decode (
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                load_start,
	input  wire                                hdr_ok,
	input  wire                                invert_mirroring,
	input  wire nes_format_pkg::header_byte_t  prg_pages,
	input  wire nes_format_pkg::header_byte_t  chr_pages,
	input  wire nes_format_pkg::header_byte_t  flags6,
	input  wire nes_format_pkg::header_byte_t  flags7,
	input  wire nes_format_pkg::header_byte_t [7:0] ext_bytes,
	output nes_cart_pkg::mapper_flags_t        mapper_flags
);
	import nes_format_pkg::*;
	import nes_cart_pkg::*;

	// Smallest k with pages <= 2^k, 7 covers everything above 64 pages
	function automatic size_code_t size_code(input header_byte_t pages);
		size_code_t code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if ({1'b0, pages} <= (9'd1 << k))
				code = size_code_t'(k);
		end
		return code;
	endfunction

	logic          is_nes20;
	logic          is_dirty;
	header_byte_t  mapper_num;
	header_byte_t  nes20_byte8;
	mapper_flags_t flags_next;

	assign is_nes20 = (flags7[3:2] == NES20_ID_VALUE);

	// Old dumps with ripper tags in bytes 8 to 15 carry junk in the
	// upper mapper nibble as well
	assign is_dirty = !is_nes20 && (|ext_bytes);

	assign mapper_num = {is_dirty ? 4'h0 : flags7[7:4], flags6[7:4]};
	assign nes20_byte8 = is_nes20 ? ext_bytes[0] : 8'h00;

	always_comb begin
		flags_next = '0;
		flags_next[FLAGS_MAPPER_MSB:FLAGS_MAPPER_LSB] = mapper_num;
		flags_next[FLAGS_PRG_SIZE_MSB:FLAGS_PRG_SIZE_LSB] = size_code(prg_pages);
		flags_next[FLAGS_CHR_SIZE_MSB:FLAGS_CHR_SIZE_LSB] = size_code(chr_pages);
		flags_next[FLAGS_MIRROR_BIT] = flags6[FLAGS6_MIRROR_BIT] ^ invert_mirroring;
		flags_next[FLAGS_CHR_RAM_BIT] = (chr_pages == 8'h00); // No CHR ROM means CHR RAM
		flags_next[FLAGS_FOUR_SCREEN_BIT] = flags6[FLAGS6_FOUR_SCREEN_BIT];
		flags_next[FLAGS_NES20_B8_MSB:FLAGS_NES20_B8_LSB] = nes20_byte8;
	end

	always_ff @(posedge clk) begin
		if (reset || load_start)
			mapper_flags <= '0;
		else if (hdr_ok)
			mapper_flags <= flags_next;
	end

endmodule

`default_nettype wire

//--- src/mem_write_stage.sv
// ********************
// Holds one pending memory write and lets it out in the console memory
// slot, the last cycle of each CE_PERIOD-long clock enable round
// ********************
`timescale 1ns/100ps
`default_nettype none

module mem_write_stage #(
	parameter int CE_PERIOD = 4
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      wr_req,
	input  wire nes_cart_pkg::cart_addr_t wr_addr,
	input  wire [7:0]                wr_data,
	output logic                     mem_write,
	output nes_cart_pkg::cart_addr_t mem_addr,
	output logic [7:0]               mem_data
);
	localparam int SLOT_W = (CE_PERIOD > 1) ? $clog2(CE_PERIOD) : 1;
	localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(CE_PERIOD - 1);

	logic [SLOT_W-1:0] slot_q; // Free-running, shared phase with the console
	logic              pending_q;

	always_ff @(posedge clk) begin
		if (reset || slot_q == SLOT_LAST)
			slot_q <= '0;
		else
			slot_q <= slot_q + 1'b1;
	end

	// A newer request overwrites one still waiting
	always_ff @(posedge clk) begin
		if (reset)
			pending_q <= 1'b0;
		else if (wr_req)
			pending_q <= 1'b1;
		else if (mem_write)
			pending_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_req) begin
			mem_addr <= wr_addr;
			mem_data <= wr_data;
		end
	end

	assign mem_write = pending_q && (slot_q == SLOT_LAST);

endmodule

`default_nettype wire

//--- src/nes_cart_loader.sv
// ********************
// Cartridge loader top. Chains header capture, flags decode, stream
// writer and the slot-timed write stage
// ********************
`timescale 1ns/100ps
`default_nettype none

module nes_cart_loader #(
	parameter int CE_PERIOD = 4 // Console runs on every 4th clock
) (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           downloading,
	input  wire                           byte_valid,
	input  wire [7:0]                     byte_data,
	input  wire                           invert_mirroring,
	output logic                          mem_write,
	output nes_cart_pkg::cart_addr_t      mem_addr,
	output logic [7:0]                    mem_data,
	output logic                          done,
	output logic                          error,
	output nes_cart_pkg::mapper_flags_t   mapper_flags
);
	import nes_format_pkg::*;
	import nes_cart_pkg::*;

	logic             load_start;
	logic             hdr_ok;
	logic             hdr_bad;
	logic             body_valid;
	header_byte_t     body_data;
	header_byte_t     prg_pages;
	header_byte_t     chr_pages;
	header_byte_t     flags6;
	header_byte_t     flags7;
	header_byte_t [7:0] ext_bytes;
	logic             wr_req;
	cart_addr_t       wr_addr;
	header_byte_t     wr_data;

	ines_header_capture u_capture (
		.clk, .reset, .downloading, .byte_valid, .byte_data,
		.load_start, .hdr_ok, .hdr_bad, .body_valid, .body_data,
		.prg_pages, .chr_pages, .flags6, .flags7, .ext_bytes
	);

	mapper_flags_decode u_flags (
		.clk, .reset, .load_start, .hdr_ok, .invert_mirroring,
		.prg_pages, .chr_pages, .flags6, .flags7, .ext_bytes,
		.mapper_flags
	);

	rom_stream_writer u_writer (
		.clk, .reset, .load_start, .hdr_ok, .hdr_bad,
		.body_valid, .body_data, .prg_pages, .chr_pages,
		.wr_req, .wr_addr, .wr_data, .done, .error
	);

	mem_write_stage #(
		.CE_PERIOD(CE_PERIOD)
	) u_stage (
		.clk, .reset, .wr_req, .wr_addr, .wr_data,
		.mem_write, .mem_addr, .mem_data
	);

endmodule

`default_nettype wire

//--- src/nes_cart_pkg.sv
// ********************
// Cartridge memory map and mapper flags word layout.
// Shared by the loader stages and the console side
// ********************
`default_nettype none

package nes_cart_pkg;

	localparam int CART_ADDR_WIDTH = 22;

	typedef logic [CART_ADDR_WIDTH-1:0] cart_addr_t;

	// PRG ROM sits at the bottom, CHR in the upper half of the 4 MB space
	localparam cart_addr_t PRG_BASE = 22'h000000;
	localparam cart_addr_t CHR_BASE = 22'h200000;

	// Log2 of the page count, rounded up
	typedef logic [2:0] size_code_t;

	typedef logic [31:0] mapper_flags_t;

	// Flags word fields, bits 31:25 are always zero
	localparam int FLAGS_MAPPER_LSB      = 0;
	localparam int FLAGS_MAPPER_MSB      = 7;
	localparam int FLAGS_PRG_SIZE_LSB    = 8;
	localparam int FLAGS_PRG_SIZE_MSB    = 10;
	localparam int FLAGS_CHR_SIZE_LSB    = 11;
	localparam int FLAGS_CHR_SIZE_MSB    = 13;
	localparam int FLAGS_MIRROR_BIT      = 14;
	localparam int FLAGS_CHR_RAM_BIT     = 15;
	localparam int FLAGS_FOUR_SCREEN_BIT = 16;
	localparam int FLAGS_NES20_B8_LSB    = 17; // NES 2.0 byte 8, mapper MSBs and submapper
	localparam int FLAGS_NES20_B8_MSB    = 24;

endpackage

`default_nettype wire

//--- src/nes_format_pkg.sv
// ********************
// iNES file-format constants and the header byte type.
// Imported by the header capture, flags decode and stream writer stages
// ********************
`default_nettype none

package nes_format_pkg;

	// One byte of the image as it arrives from the host
	typedef logic [7:0] header_byte_t;

	localparam int INES_HEADER_BYTES = 16;

	// Signature "NES" followed by MS-DOS end of file
	localparam header_byte_t INES_SIG0 = 8'h4E; // N
	localparam header_byte_t INES_SIG1 = 8'h45; // E
	localparam header_byte_t INES_SIG2 = 8'h53; // S
	localparam header_byte_t INES_SIG3 = 8'h1A;

	// Page sizes counted by header bytes 4 and 5
	localparam int PRG_PAGE_BYTES = 16384;
	localparam int CHR_PAGE_BYTES = 8192;

	// Bit positions inside header byte 6
	localparam int FLAGS6_MIRROR_BIT      = 0; // 1 = vertical
	localparam int FLAGS6_TRAINER_BIT     = 2; // 512-byte trainer present, not supported
	localparam int FLAGS6_FOUR_SCREEN_BIT = 3;

	// Byte 7 bits 3:2 hold this value in an NES 2.0 header
	localparam logic [1:0] NES20_ID_VALUE = 2'd2;

endpackage

`default_nettype wire

//--- src/rom_stream_writer.sv
// ********************
// Counts the PRG and CHR body bytes and turns each one into a write
// request with its cartridge address. Drives the done and error levels
// ********************
`timescale 1ns/100ps
`default_nettype none

module rom_stream_writer (
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               load_start,
	input  wire                               hdr_ok,
	input  wire                               hdr_bad,
	input  wire                               body_valid,
	input  wire nes_format_pkg::header_byte_t body_data,
	input  wire nes_format_pkg::header_byte_t prg_pages,
	input  wire nes_format_pkg::header_byte_t chr_pages,
	output logic                              wr_req,
	output nes_cart_pkg::cart_addr_t          wr_addr,
	output nes_format_pkg::header_byte_t      wr_data,
	output logic                              done,
	output logic                              error
);
	import nes_format_pkg::*;
	import nes_cart_pkg::*;

	typedef enum logic [1:0] {
		PH_PRG,
		PH_CHR,
		PH_END // Idle between images and after the last counted byte
	} phase_t;

	phase_t     phase;
	cart_addr_t bytes_left;
	cart_addr_t next_addr;
	cart_addr_t prg_bytes;
	cart_addr_t chr_bytes;
	logic       accept;
	logic       last_byte;

	// 255 PRG pages still fit in 22 bits
	assign prg_bytes = cart_addr_t'(prg_pages) * cart_addr_t'(PRG_PAGE_BYTES);
	assign chr_bytes = cart_addr_t'(chr_pages) * cart_addr_t'(CHR_PAGE_BYTES);

	assign accept = body_valid && (phase != PH_END); // Trailing bytes fall through
	assign last_byte = (bytes_left == cart_addr_t'(1));

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= PH_END;
			bytes_left <= '0;
			wr_req <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			wr_req <= 1'b0;
			if (load_start) begin
				phase <= PH_END;
				done <= 1'b0;
				error <= 1'b0;
			end else if (hdr_bad) begin
				phase <= PH_END;
				done <= 1'b1;
				error <= 1'b1;
			end else if (hdr_ok) begin
				if (prg_pages != 8'h00) begin
					phase <= PH_PRG;
					bytes_left <= prg_bytes;
				end else if (chr_pages != 8'h00) begin
					phase <= PH_CHR;
					bytes_left <= chr_bytes;
				end else begin
					done <= 1'b1; // Empty image
				end
			end else if (accept) begin
				wr_req <= 1'b1;
				bytes_left <= bytes_left - 1'b1;
				if (last_byte) begin
					if (phase == PH_PRG && chr_pages != 8'h00) begin
						phase <= PH_CHR;
						bytes_left <= chr_bytes;
					end else begin
						phase <= PH_END;
						done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_ok) begin
			next_addr <= (prg_pages != 8'h00) ? PRG_BASE : CHR_BASE;
		end else if (accept) begin
			wr_addr <= next_addr;
			wr_data <= body_data;
			// Jump to the CHR region after the last PRG byte
			next_addr <= (last_byte && phase == PH_PRG) ? CHR_BASE : next_addr + 1'b1;
		end
	end

endmodule

`default_nettype wire
